//--- hdl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`default_nettype none

// ******************************
// core geometry
// ******************************

`define CORE_XLEN       32  // width of every operand, result and address word
`define CORE_NUM_REGS   32  // architectural integer registers x0 to x31
`define CORE_TAG_BITS   6   // reorder tag width, the counter wraps after 64 issues

// ******************************
// pipeline depth
// ******************************

`define CORE_EXU_STAGES 2   // cycles from the issue edge to the result register

`default_nettype wire

`endif

//--- hdl/issue_pkg.sv
`include "core_settings.svh"

`default_nettype none

package issue_pkg;

    // ******************************
    // plain vector types
    // ******************************

    typedef logic [`CORE_XLEN-1:0]             data_word_t;  // operand, result or pc
    typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_addr_t;   // architectural register index
    typedef logic [`CORE_TAG_BITS-1:0]         rob_tag_t;    // issue order tag
    typedef logic [11:0]                       imm_t;        // i-type immediate, sign extended on use

    // alu operations understood by the execution unit
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,  // shift amount is the low five bits of operand b
        SRL = 3'd6,
        SLT = 3'd7   // signed compare gives 1 or 0
    } alu_op_t;

    // ******************************
    // packets
    // ******************************

    typedef struct packed {
        alu_op_t         alu_op;      // ignored for jumps which always add
        reg_addr_t [1:0] rs;          // rs[0] also feeds the branch target adder
        reg_addr_t       rd;          // x0 means no architectural result
        imm_t      [1:0] imm;         // imm[0] is the jalr offset
        logic      [1:0] imm_valid;   // per operand choice of immediate over register
        logic            jump;        // link value is pc plus 2 or 4
        logic            compressed;  // 16 bit encoding so the link step is 2
        logic            fence;       // waits for an empty pipeline
        data_word_t      pc;          // instruction address
    } decoded_instr_t;

    typedef struct packed {
        data_word_t op_a;    // first alu operand after selection
        data_word_t op_b;    // second alu operand after selection
        alu_op_t    alu_op;
        reg_addr_t  rd;
        rob_tag_t   tag;     // issue order tag handed on to the result
        data_word_t pc;
    } issue_packet_t;

    typedef struct packed {
        reg_addr_t  rd;      // register to write, x0 writes are dropped
        data_word_t data;
    } writeback_t;

    typedef struct packed {
        rob_tag_t   tag;
        reg_addr_t  rd;
        data_word_t data;
        data_word_t pc;
    } result_packet_t;

endpackage

`default_nettype wire

//--- hdl/register_file.sv
`include "core_settings.svh"

`default_nettype none

module register_file (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        wb_valid_i,  // one write per cycle
    input  issue_pkg::writeback_t       wb_i,
    input  issue_pkg::reg_addr_t [1:0]  rs_i,
    output issue_pkg::data_word_t [1:0] rs_data_o
);

    import issue_pkg::*;

    data_word_t regs_q [`CORE_NUM_REGS];  // entry 0 is cleared by reset and never written

    // ******************************
    // write port
    // ******************************

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < `CORE_NUM_REGS; r++) begin
                regs_q[r] <= '0;  // every register reads zero after reset
            end
        end else if (wb_valid_i && wb_i.rd != '0) begin
            regs_q[wb_i.rd] <= wb_i.data;  // x0 stays zero
        end
    end

    // ******************************
    // read ports
    // ******************************

    // reads see the old value in a write cycle and the scheduler forwards over them
    assign rs_data_o[0] = regs_q[rs_i[0]];
    assign rs_data_o[1] = regs_q[rs_i[1]];

endmodule

`default_nettype wire

//--- hdl/scoreboard.sv
`include "core_settings.svh"

`default_nettype none

module scoreboard (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,        // drops every pending destination
    input  logic                      issue_i,        // instruction accepted this cycle
    input  issue_pkg::decoded_instr_t instr_i,
    input  logic                      instr_valid_i,
    input  logic                      wb_valid_i,
    input  issue_pkg::writeback_t     wb_i,
    output logic                      stall_o
);

    logic [`CORE_NUM_REGS-1:0] busy_q;        // one pending write per register
    logic [1:0]                reads;         // operand really comes from the register file
    logic [1:0]                src_hazard;    // operand waits for a result not yet written
    logic                      pipeline_empty;

    // ******************************
    // busy bits
    // ******************************

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            busy_q <= '0;
        end else begin
            if (wb_valid_i) begin
                busy_q[wb_i.rd] <= 1'b0;  // result has reached the register file
            end
            if (issue_i && instr_i.rd != '0) begin
                busy_q[instr_i.rd] <= 1'b1;  // later assignment wins on a same cycle writeback
            end
        end
    end

    // ******************************
    // stall decision
    // ******************************

    always_comb begin
        reads[0] = instr_i.jump || !instr_i.imm_valid[0];   // jumps read rs1 for the target
        reads[1] = !instr_i.jump && !instr_i.imm_valid[1];  // jumps use a constant here
        for (int i = 0; i < 2; i++) begin
            // a writeback in this cycle is forwarded, so it does not hold the instruction
            src_hazard[i] = reads[i] && busy_q[instr_i.rs[i]]
                            && !(wb_valid_i && wb_i.rd == instr_i.rs[i]);
        end
    end

    assign pipeline_empty = (busy_q == '0);  // nothing left to write back

    // a fence also waits for every pending write to drain
    assign stall_o = instr_valid_i && ((|src_hazard) || (instr_i.fence && !pipeline_empty));

endmodule

`default_nettype wire

//--- hdl/scheduler.sv
`default_nettype none

module scheduler (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      instr_valid_i,    // held by the source while stalled
    input  issue_pkg::decoded_instr_t instr_i,
    input  logic                      wb_valid_i,
    input  issue_pkg::writeback_t     wb_i,
    output logic                      stall_o,          // combinational back-pressure
    output issue_pkg::data_word_t     branch_target_o,  // rs1 plus imm0 for jalr
    output logic                      issue_valid_o,
    output issue_pkg::issue_packet_t  issue_o
);

    import issue_pkg::*;

    data_word_t [1:0] rf_data;        // raw register file read data
    data_word_t [1:0] reg_op;         // register operands after forwarding
    data_word_t [1:0] imm_op;         // immediates widened to a full word
    data_word_t [1:0] operand;        // operands handed to the execution unit
    alu_op_t          alu_op;
    logic             issue;          // valid instruction without a stall
    rob_tag_t         tag_q;          // tag of the next instruction to issue
    logic             issue_valid_q;  // pipeline stage 1 valid
    issue_packet_t    issue_q;        // pipeline stage 1 payload

    // ******************************
    // register read and scoreboard
    // ******************************

    register_file rf0 (
        .clk_i      ( clk_i       ),
        .rst_n_i    ( rst_n_i     ),
        .wb_valid_i ( wb_valid_i  ),
        .wb_i       ( wb_i        ),
        .rs_i       ( instr_i.rs  ),
        .rs_data_o  ( rf_data     )
    );

    scoreboard sb0 (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .flush_i       ( flush_i       ),
        .issue_i       ( issue         ),
        .instr_i       ( instr_i       ),
        .instr_valid_i ( instr_valid_i ),
        .wb_valid_i    ( wb_valid_i    ),
        .wb_i          ( wb_i          ),
        .stall_o       ( stall_o       )
    );

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            imm_op[i] = data_word_t'(signed'(instr_i.imm[i]));  // sign extend the 12 bit field
            // the register file only takes the write at the next edge
            if (wb_valid_i && wb_i.rd == instr_i.rs[i] && wb_i.rd != '0) begin
                reg_op[i] = wb_i.data;
            end else begin
                reg_op[i] = rf_data[i];
            end
        end
    end

    // ******************************
    // operand selection
    // ******************************

    always_comb begin
        if (instr_i.jump) begin
            operand[0] = instr_i.pc;  // link value is pc plus the instruction size
            operand[1] = instr_i.compressed ? data_word_t'(2) : data_word_t'(4);
            alu_op     = ADD;
        end else begin
            for (int i = 0; i < 2; i++) begin
                operand[i] = instr_i.imm_valid[i] ? imm_op[i] : reg_op[i];
            end
            alu_op = instr_i.alu_op;
        end
    end

    assign branch_target_o = reg_op[0] + imm_op[0];  // meaningful only while jump is set

    // ******************************
    // tags and stage 1 register
    // ******************************

    assign issue = instr_valid_i && !stall_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            tag_q         <= '0;    // numbering restarts after a flush
            issue_valid_q <= 1'b0;  // an instruction issued with the flush is dropped
        end else begin
            issue_valid_q <= issue;
            if (issue) begin
                tag_q <= tag_q + 1'b1;  // jumps take a tag too
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            issue_q <= '{op_a:   operand[0],
                         op_b:   operand[1],
                         alu_op: alu_op,
                         rd:     instr_i.rd,
                         tag:    tag_q,
                         pc:     instr_i.pc};
        end
    end

    assign issue_valid_o = issue_valid_q;
    assign issue_o       = issue_q;

endmodule

`default_nettype wire

//--- hdl/int_exec_unit.sv
`include "core_settings.svh"

`default_nettype none

module int_exec_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,         // kills results still in flight
    input  logic                      issue_valid_i,   // one instruction per cycle at most
    input  issue_pkg::issue_packet_t  issue_i,
    output logic                      wb_valid_o,
    output issue_pkg::writeback_t     wb_o,
    output logic                      result_valid_o,  // same event as wb_valid_o
    output issue_pkg::result_packet_t result_o
);

    import issue_pkg::*;

    localparam int unsigned EXU_REGS = `CORE_EXU_STAGES - 1;  // stage 1 sits in the scheduler

    data_word_t          alu_res;           // combinational result of the incoming packet
    logic [EXU_REGS-1:0] valid_q;           // valid bit per internal stage
    result_packet_t      res_q [EXU_REGS];  // payload per internal stage

    // ******************************
    // alu
    // ******************************

    always_comb begin
        case (issue_i.alu_op)
            ADD: alu_res = issue_i.op_a + issue_i.op_b;
            SUB: alu_res = issue_i.op_a - issue_i.op_b;
            AND: alu_res = issue_i.op_a & issue_i.op_b;
            OR:  alu_res = issue_i.op_a | issue_i.op_b;
            XOR: alu_res = issue_i.op_a ^ issue_i.op_b;
            SLL: alu_res = issue_i.op_a << issue_i.op_b[4:0];
            SRL: alu_res = issue_i.op_a >> issue_i.op_b[4:0];  // logical shift
            SLT: alu_res = data_word_t'($signed(issue_i.op_a) < $signed(issue_i.op_b));
        endcase
    end

    // ******************************
    // result stages
    // ******************************

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= issue_valid_i;
            for (int s = 1; s < EXU_REGS; s++) begin
                valid_q[s] <= valid_q[s-1];  // fixed latency keeps results in issue order
            end
        end
    end

    always_ff @(posedge clk_i) begin
        res_q[0] <= '{tag: issue_i.tag, rd: issue_i.rd, data: alu_res, pc: issue_i.pc};
        for (int s = 1; s < EXU_REGS; s++) begin
            res_q[s] <= res_q[s-1];
        end
    end

    // writeback and result packet come from the same final register
    assign wb_valid_o     = valid_q[EXU_REGS-1];
    assign wb_o           = '{rd: res_q[EXU_REGS-1].rd, data: res_q[EXU_REGS-1].data};
    assign result_valid_o = valid_q[EXU_REGS-1];
    assign result_o       = res_q[EXU_REGS-1];

endmodule

`default_nettype wire

//--- hdl/issue_top.sv
`default_nettype none

module issue_top (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      instr_valid_i,
    input  issue_pkg::decoded_instr_t instr_i,
    output logic                      stall_o,          // source holds instr_i while high
    output issue_pkg::data_word_t     branch_target_o,
    output logic                      result_valid_o,   // two cycles after the issue edge
    output issue_pkg::result_packet_t result_o
);

    import issue_pkg::*;

    logic          issue_valid;  // stage 1 strobe into the execution unit
    issue_packet_t issue;
    logic          wb_valid;     // stage 2 strobe back into the scheduler
    writeback_t    wb;

    // ******************************
    // issue stage
    // ******************************

    scheduler sched0 (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .flush_i         ( flush_i         ),
        .instr_valid_i   ( instr_valid_i   ),
        .instr_i         ( instr_i         ),
        .wb_valid_i      ( wb_valid        ),
        .wb_i            ( wb              ),
        .stall_o         ( stall_o         ),
        .branch_target_o ( branch_target_o ),
        .issue_valid_o   ( issue_valid     ),
        .issue_o         ( issue           )
    );

    // ******************************
    // execution and writeback
    // ******************************

    int_exec_unit exu0 (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .flush_i        ( flush_i        ),
        .issue_valid_i  ( issue_valid    ),
        .issue_i        ( issue          ),
        .wb_valid_o     ( wb_valid       ),  // feeds register file, scoreboard and forwarding
        .wb_o           ( wb             ),
        .result_valid_o ( result_valid_o ),
        .result_o       ( result_o       )
    );

endmodule

`default_nettype wire

//--- sim/issue_tb.sv
`include "core_settings.svh"

`default_nettype none

module issue_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import issue_pkg::*;

    localparam int NUM_ENTRIES    = 25;
    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * (`CORE_EXU_STAGES + 2) + 40;

    localparam logic [2:0] KIND_ALU   = 3'b000;  // bits are jump, compressed, fence
    localparam logic [2:0] KIND_JAL   = 3'b100;
    localparam logic [2:0] KIND_JAL_C = 3'b110;
    localparam logic [2:0] KIND_FENCE = 3'b001;

    logic           clk_i = 1'b0;
    logic           rst_n_i;
    logic           flush_i;
    logic           instr_valid_i;
    decoded_instr_t instr_i;
    logic           stall_o;
    data_word_t     branch_target_o;
    logic           result_valid_o;
    result_packet_t result_o;

    decoded_instr_t stim_instr [NUM_ENTRIES];  // decoded instructions in issue order
    int             stim_test  [NUM_ENTRIES];  // behavior each entry belongs to
    logic           stim_flush [NUM_ENTRIES];  // flush the pipeline before presenting it
    logic           stim_stall [NUM_ENTRIES];  // its dependency must hold it at least once
    int             n_entries = 0;

    data_word_t     spec_regs [`CORE_NUM_REGS];  // register state seen at issue
    data_word_t     arch_regs [`CORE_NUM_REGS];  // state of checked results, restored on flush
    rob_tag_t       exp_tag;                     // tag the next accepted entry must carry
    result_packet_t exp_q [$];                   // results still expected, oldest first
    int             exp_test_q [$];
    int             test_errors [NUM_TESTS+1] = '{default: 0};
    int             test_stalls [NUM_TESTS+1] = '{default: 0};
    string          test_name [NUM_TESTS+1] = '{"", "alu ops", "dependent ops", "x0 writes",
                                                "jumps", "fence", "flush"};
    int             cur_test    = 1;
    int             error_count = 0;
    int             cycle_count = 0;

    issue_top dut0 (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .flush_i         ( flush_i         ),
        .instr_valid_i   ( instr_valid_i   ),
        .instr_i         ( instr_i         ),
        .stall_o         ( stall_o         ),
        .branch_target_o ( branch_target_o ),
        .result_valid_o  ( result_valid_o  ),
        .result_o        ( result_o        )
    );

    always #50 clk_i = ~clk_i;  // 100 ns period

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // ******************************
    // reference model
    // ******************************

    function automatic data_word_t sign_extend(input imm_t imm);
        return {{(`CORE_XLEN-12){imm[11]}}, imm};  // 12 bit immediate to a full word
    endfunction

    function automatic data_word_t expected_alu(input alu_op_t op, input data_word_t a,
                                                input data_word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];  // only five bits of shift amount count
            SRL:     return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? data_word_t'(1) : data_word_t'(0);
        endcase
    endfunction

    task automatic count_error(input int t);
        error_count++;
        test_errors[t]++;
    endtask

    task automatic report_mismatch(input string name, input data_word_t want,
                                   input data_word_t got, input int t);
        $display("ERR %s: expected %h, got %h", name, want, got);
        count_error(t);
    endtask

    task automatic accept_entry(input int idx);
        decoded_instr_t d;
        data_word_t     a;
        data_word_t     b;
        result_packet_t want;
        d = stim_instr[idx];
        if (d.jump) begin
            a         = d.pc;  // link is the address of the next instruction
            b         = d.compressed ? data_word_t'(2) : data_word_t'(4);
            want.data = a + b;
        end else begin
            a         = d.imm_valid[0] ? sign_extend(d.imm[0]) : spec_regs[d.rs[0]];
            b         = d.imm_valid[1] ? sign_extend(d.imm[1]) : spec_regs[d.rs[1]];
            want.data = expected_alu(d.alu_op, a, b);
        end
        want.tag = exp_tag;
        want.rd  = d.rd;
        want.pc  = d.pc;
        exp_q.push_back(want);
        exp_test_q.push_back(stim_test[idx]);
        if (d.rd != '0) begin
            spec_regs[d.rd] = want.data;  // x0 keeps reading zero
        end
        exp_tag = exp_tag + 1'b1;
    endtask

    // ******************************
    // stimulus table
    // ******************************

    task automatic add_entry(input int test, input alu_op_t op, input int rs0, input int rs1,
                             input int rd, input imm_t imm0, input imm_t imm1,
                             input logic [1:0] iv, input logic [2:0] kind,
                             input logic flush, input logic stall);
        decoded_instr_t d;
        d.alu_op    = op;
        d.rs[0]     = reg_addr_t'(rs0);
        d.rs[1]     = reg_addr_t'(rs1);
        d.rd        = reg_addr_t'(rd);
        d.imm[0]    = imm0;
        d.imm[1]    = imm1;
        d.imm_valid = iv;  // bit 0 picks the immediate for operand a
        {d.jump, d.compressed, d.fence} = kind;
        d.pc        = data_word_t'(32'h0000_1000 + 4 * n_entries);
        stim_instr[n_entries] = d;
        stim_test[n_entries]  = test;
        stim_flush[n_entries] = flush;
        stim_stall[n_entries] = stall;
        n_entries++;
    endtask

    task automatic load_table();
        // test op rs0 rs1 rd imm0 imm1 imm_valid kind flush stall
        add_entry(1, ADD, 0, 0, 1, 12'h123, 12'h045, 2'b11, KIND_ALU, 0, 0);
        add_entry(1, SUB, 0, 0, 2, 12'h010, 12'h7ff, 2'b11, KIND_ALU, 0, 0);
        add_entry(1, AND, 1, 0, 3, 12'h000, 12'h0f0, 2'b10, KIND_ALU, 0, 0);
        add_entry(1, OR,  2, 0, 4, 12'h000, 12'h300, 2'b10, KIND_ALU, 0, 0);
        add_entry(1, XOR, 1, 2, 5, 12'h000, 12'h000, 2'b00, KIND_ALU, 0, 0);
        add_entry(1, SLL, 1, 0, 6, 12'h000, 12'h005, 2'b10, KIND_ALU, 0, 0);
        add_entry(1, SRL, 0, 0, 7, 12'h800, 12'h003, 2'b11, KIND_ALU, 0, 0);
        add_entry(1, SLT, 2, 1, 8, 12'h000, 12'h000, 2'b00, KIND_ALU, 0, 0);
        add_entry(2, ADD, 1, 0, 9, 12'h000, 12'h001, 2'b10, KIND_ALU, 0, 0);
        add_entry(2, ADD, 9, 9, 10, 12'h000, 12'h000, 2'b00, KIND_ALU, 0, 1);
        add_entry(2, SUB, 10, 0, 11, 12'h000, 12'h003, 2'b10, KIND_ALU, 0, 1);
        add_entry(2, XOR, 11, 9, 9, 12'h000, 12'h000, 2'b00, KIND_ALU, 0, 1);
        add_entry(3, ADD, 0, 0, 0, 12'h555, 12'h111, 2'b11, KIND_ALU, 0, 0);
        add_entry(3, OR,  0, 0, 13, 12'h001, 12'h002, 2'b11, KIND_ALU, 0, 0);
        add_entry(3, ADD, 0, 0, 12, 12'h000, 12'h000, 2'b00, KIND_ALU, 0, 0);  // x0 writeback visible
        // x0 now comes from the register file after its write
        add_entry(3, XOR, 13, 0, 22, 12'h000, 12'h000, 2'b00, KIND_ALU, 0, 0);
        add_entry(4, ADD, 1, 0, 14, 12'h010, 12'h000, 2'b00, KIND_JAL, 0, 0);
        add_entry(4, ADD, 14, 0, 15, 12'hffc, 12'h000, 2'b00, KIND_JAL_C, 0, 1);
        add_entry(4, ADD, 15, 0, 16, 12'h000, 12'h000, 2'b10, KIND_ALU, 0, 1);
        add_entry(5, ADD, 0, 0, 17, 12'h0aa, 12'h0bb, 2'b11, KIND_ALU, 0, 0);
        add_entry(5, ADD, 0, 0, 0, 12'h000, 12'h000, 2'b11, KIND_FENCE, 0, 1);
        add_entry(5, ADD, 17, 16, 18, 12'h000, 12'h000, 2'b00, KIND_ALU, 0, 0);
        add_entry(6, ADD, 0, 0, 19, 12'h100, 12'h001, 2'b11, KIND_ALU, 0, 0);
        add_entry(6, ADD, 0, 0, 20, 12'h200, 12'h002, 2'b11, KIND_ALU, 0, 0);  // killed in flight
        add_entry(6, ADD, 20, 19, 21, 12'h000, 12'h000, 2'b00, KIND_ALU, 1, 0);
    endtask

    // ******************************
    // drivers
    // ******************************

    task automatic present_entry(input int idx);
        int         stalls;
        data_word_t target;
        stalls = 0;
        @(negedge clk_i);
        flush_i       = 1'b0;
        instr_i       = stim_instr[idx];
        instr_valid_i = 1'b1;
        #1;
        while (stall_o) begin  // the entry stays on the inputs until stall_o drops
            stalls++;
            @(negedge clk_i);
            #1;
        end
        test_stalls[stim_test[idx]] += stalls;
        if (stim_stall[idx] && stalls == 0) begin
            $display("entry %0d issued at once although its source was still pending", idx);
            count_error(stim_test[idx]);
        end else if (!stim_stall[idx] && stalls != 0) begin
            $display("entry %0d stalled %0d cycles although its operands were ready",
                     idx, stalls);
            count_error(stim_test[idx]);
        end
        if (instr_i.fence && exp_q.size() != 0) begin
            $display("fence at entry %0d issued with %0d results outstanding", idx, exp_q.size());
            count_error(stim_test[idx]);
        end
        if (instr_i.jump) begin
            target = spec_regs[instr_i.rs[0]] + sign_extend(instr_i.imm[0]);  // jalr form
            if (branch_target_o !== target) begin
                report_mismatch("branch_target_o", target, branch_target_o, stim_test[idx]);
            end
        end
        accept_entry(idx);
        @(posedge clk_i);  // the issue edge
    endtask

    task automatic apply_flush();
        @(negedge clk_i);
        instr_valid_i = 1'b0;
        flush_i       = 1'b1;
        @(posedge clk_i);
        spec_regs = arch_regs;  // writes still in flight never land
        exp_q.delete();
        exp_test_q.delete();
        exp_tag = '0;
    endtask

    task automatic finish_test(input int t);
        @(negedge clk_i);
        instr_valid_i = 1'b0;
        #1;
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
            #1;
        end
        repeat (`CORE_EXU_STAGES + 1) @(negedge clk_i);  // room for a stray result to show up
        $display("test %0d %s: %s, %0d errors, %0d stall cycles", t, test_name[t],
                 (test_errors[t] == 0) ? "ok" : "FAILED", test_errors[t], test_stalls[t]);
    endtask

    // ******************************
    // result checker
    // ******************************

    always @(negedge clk_i) begin
        result_packet_t want;
        int             t;
        if (rst_n_i && result_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("result with tag %h arrived although nothing was pending", result_o.tag);
                count_error(cur_test);
            end else begin
                want = exp_q.pop_front();
                t    = exp_test_q.pop_front();
                if (result_o.tag !== want.tag) begin
                    report_mismatch("result_o.tag", data_word_t'(want.tag),
                                    data_word_t'(result_o.tag), t);
                end
                if (result_o.rd !== want.rd) begin
                    report_mismatch("result_o.rd", data_word_t'(want.rd),
                                    data_word_t'(result_o.rd), t);
                end
                if (result_o.data !== want.data) begin
                    report_mismatch("result_o.data", want.data, result_o.data, t);
                end
                if (result_o.pc !== want.pc) begin
                    report_mismatch("result_o.pc", want.pc, result_o.pc, t);
                end
                if (want.rd != '0) begin
                    arch_regs[want.rd] = want.data;  // written back by now
                end
            end
        end
    end

    initial begin
        int passed;
        int failed;
        passed        = 0;
        failed        = 0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        exp_tag       = '0;
        for (int r = 0; r < `CORE_NUM_REGS; r++) begin
            spec_regs[r] = '0;  // reset clears the whole register file
            arch_regs[r] = '0;
        end
        load_table();
        repeat (10) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        if (stall_o !== 1'b0) begin
            report_mismatch("stall_o", '0, data_word_t'(stall_o), 1);
        end
        if (result_valid_o !== 1'b0) begin
            report_mismatch("result_valid_o", '0, data_word_t'(result_valid_o), 1);
        end
        for (int i = 0; i < n_entries; i++) begin
            if (i > 0 && stim_test[i] != stim_test[i-1]) begin
                finish_test(stim_test[i-1]);
            end
            cur_test = stim_test[i];
            if (stim_flush[i]) begin
                apply_flush();
            end
            present_entry(i);
        end
        finish_test(stim_test[n_entries-1]);
        for (int t = 1; t <= NUM_TESTS; t++) begin
            if (test_errors[t] == 0) begin
                passed++;
            end else begin
                failed++;
            end
        end
        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/issue_pkg.sv
hdl/register_file.sv
hdl/scoreboard.sv
hdl/scheduler.sv
hdl/int_exec_unit.sv
hdl/issue_top.sv
sim/issue_tb.sv

//--- run_sim.sh
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module issue_tb -o issue_sim
./obj_dir/issue_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
grep -q "Simulation passed" sim.log
